// File: vlog.f
hdl/hyperbus_pkg.sv
hdl/hyper_cmd_addr.sv
hdl/hyper_latency_counter.sv
hdl/hyper_word_fifo.sv
hdl/hyper_trans_fsm.sv
hdl/hyperbus_phy.sv
bench/hyperram_model.sv
bench/tb_hyperbus_phy.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_hyperbus_phy \
    -Mdir obj_dir > sim.log 2>&1 \
    && ./obj_dir/Vtb_hyperbus_phy >> sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } \
    || { echo "PASS"; exit 0; }

// File: bench/tb_hyperbus_phy.sv
// testbench for the HyperBus PHY
//   clock, reset and Galois LFSR stimulus
//   shadow memories per chip select as reference
//   read compare process, bus idle checks, watchdog
module tb_hyperbus_phy import hyperbus_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned WAIT_CYCLES = 6;
    localparam int unsigned FIFO_DEPTH  = 8;
    // upper bound of words moved by all tests, writes and reads
    localparam int unsigned WORD_BUDGET = 2 + 6 * 2 * 20 + 3 * 12 + 2 * 40 + 4 * 4 + 2 * 16;
    localparam int unsigned WDOG_CYCLES = WORD_BUDGET * (3 * WAIT_CYCLES + 8) + 2000;

    typedef logic [$clog2(NR_CS)-1:0] cs_idx_t;
    typedef enum logic [1:0] {RX_ALWAYS, RX_HOLD, RX_RANDOM} rx_mode_e;

    logic         clk0, rst_ni;
    logic         trans_valid_i, trans_ready_o;
    trans_req_t   trans_i;
    logic         tx_valid_i, tx_ready_o;
    tx_word_t     tx_i;
    logic         rx_valid_o, rx_ready_i;
    hyper_word_t  rx_o;
    hyper_bus_o_t bus_o;
    hyper_bus_i_t bus_i;

    hyper_word_t  shadow_mem [NR_CS][4096];
    hyper_word_t  exp_q [$];  // read words still owed by the DUT
    tx_word_t     tx_q [$];
    logic [31:0]  lfsr_q  = 32'h1ae1_4fc9;
    rx_mode_e     rx_mode = RX_ALWAYS;
    int unsigned  err_cnt, check_cnt, test_no;

    hyperbus_phy #(.WAIT_CYCLES(WAIT_CYCLES), .FIFO_DEPTH(FIFO_DEPTH)) dut_i (.*);

    hyperram_model #(.WAIT_CYCLES(WAIT_CYCLES)) u_ram (
        .clk0   ( clk0   ),
        .rst_ni ( rst_ni ),
        .ctrl_i ( bus_o  ),
        .resp_o ( bus_i  )
    );

    initial begin
        clk0 = 1'b0;
        forever #50 clk0 = ~clk0;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);  // one step per bit
        end
        return v;
    endfunction

    // memory word after a strobed write
    function automatic hyper_word_t merge_strobed(hyper_word_t old, tx_word_t w);
        hyper_word_t r;
        r = old;
        if (w.strb[0]) r[7:0] = w.data[7:0];
        if (w.strb[1]) r[15:8] = w.data[15:8];
        return r;
    endfunction

    function automatic trans_req_t make_req(cs_idx_t cs, logic [11:0] addr, logic wr,
                                            int unsigned len);
        trans_req_t r;
        r         = '0;
        r.address = {20'b0, addr};
        r.cs[cs]  = 1'b1;
        r.write   = wr;
        r.burst   = BURST_WIDTH'(len);
        return r;
    endfunction

    task automatic check_word(hyper_word_t got, hyper_word_t expected);
        check_cnt++;
        if (got !== expected) begin
            err_cnt++;
            $display("CHECK FAILED @%0t: read word %h, expected %h", $time, got, expected);
        end
    endtask

    task automatic check_bus_idle(hyper_bus_o_t b);
        check_cnt++;
        if (b.cs_n !== '1 || b.dq_oe !== 1'b0 || b.rwds_oe !== 1'b0) begin
            err_cnt++;
            $display("CHECK FAILED @%0t: bus not idle, cs_n %b dq_oe %b rwds_oe %b",
                     $time, b.cs_n, b.dq_oe, b.rwds_oe);
        end
    endtask

    // called on a falling edge
    task automatic send_req(trans_req_t r);
        trans_i       = r;
        trans_valid_i = 1'b1;
        while (!trans_ready_o) @(negedge clk0);
        @(negedge clk0);  // taken on the rising edge in between
        trans_valid_i = 1'b0;
    endtask

    task automatic wait_done();
        while (!trans_ready_o || exp_q.size() != 0) @(negedge clk0);
        check_bus_idle(bus_o);
    endtask

    task automatic run_write(cs_idx_t cs, logic [11:0] addr, int unsigned len,
                             logic partial, logic gaps);
        tx_word_t    w;
        logic [11:0] a;
        for (int unsigned i = 0; i < len; i++) begin
            a      = addr + 12'(i);
            w.data = hyper_word_t'(take_bits(16));
            w.strb = partial ? 2'(take_bits(2)) : 2'b11;
            shadow_mem[cs][a] = merge_strobed(shadow_mem[cs][a], w);
            tx_q.push_back(w);
        end
        fork
            send_req(make_req(cs, addr, 1'b1, len));
            while (tx_q.size() != 0) begin
                if (gaps) begin
                    repeat (take_bits(2)) @(negedge clk0);
                end
                tx_i       = tx_q[0];
                tx_valid_i = 1'b1;
                while (!tx_ready_o) @(negedge clk0);
                @(negedge clk0);
                void'(tx_q.pop_front());
                tx_valid_i = 1'b0;
            end
        join
        wait_done();
    endtask

    task automatic run_read(cs_idx_t cs, logic [11:0] addr, int unsigned len);
        logic [11:0] a;
        for (int unsigned i = 0; i < len; i++) begin
            a = addr + 12'(i);
            exp_q.push_back(shadow_mem[cs][a]);
        end
        send_req(make_req(cs, addr, 1'b0, len));
        wait_done();
    endtask

    task automatic end_test(string name, int unsigned errs_before);
        test_no++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", test_no, name);
        end else begin
            $display("test %0d %s: %0d errors", test_no, name, err_cnt - errs_before);
        end
    endtask

    // rx ready policy and compare, both decided on the falling edge
    initial begin
        forever begin
            @(negedge clk0);
            case (rx_mode)
                RX_HOLD:   rx_ready_i = 1'b0;
                RX_RANDOM: rx_ready_i = 1'(take_bits(1));
                default:   rx_ready_i = 1'b1;
            endcase
            if (rx_valid_o && rx_ready_i) begin
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("@%0t: read word %h arrived with no read outstanding", $time, rx_o);
                end else begin
                    check_word(rx_o, exp_q.pop_front());
                end
            end
        end
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk0);
        $display("watchdog: tests did not finish within %0d cycles", WDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int unsigned errs;
        int unsigned len;
        rst_ni        = 1'b0;
        trans_valid_i = 1'b0;
        trans_i       = '0;
        tx_valid_i    = 1'b0;
        tx_i          = '0;
        rx_ready_i    = 1'b1;
        err_cnt       = 0;
        check_cnt     = 0;
        test_no       = 0;
        repeat (5) @(posedge clk0);
        @(negedge clk0);
        rst_ni = 1'b1;
        @(negedge clk0);

        errs = err_cnt;
        run_write(1'b0, 12'h010, 1, 1'b0, 1'b0);
        run_read(1'b0, 12'h010, 1);
        end_test("single word", errs);

        errs = err_cnt;
        for (int unsigned i = 0; i < 6; i++) begin
            len = (i == 0) ? 20 : 1 + take_bits(5) % 20;  // first one exceeds the FIFO
            run_write(cs_idx_t'(i), 12'h100 + 12'(i * 32), len, 1'b0, 1'b0);
            run_read(cs_idx_t'(i), 12'h100 + 12'(i * 32), len);
        end
        end_test("random bursts", errs);

        errs = err_cnt;
        run_write(1'b0, 12'h300, 12, 1'b0, 1'b0);
        run_write(1'b0, 12'h300, 12, 1'b1, 1'b0);  // partial strobes over known data
        run_read(1'b0, 12'h300, 12);
        end_test("partial strobes", errs);

        errs = err_cnt;
        run_write(1'b1, 12'h200, 40, 1'b0, 1'b0);
        rx_mode = RX_HOLD;
        fork
            run_read(1'b1, 12'h200, 40);
            begin
                repeat (40) @(negedge clk0);
                rx_mode = RX_RANDOM;
            end
        join
        rx_mode = RX_ALWAYS;
        end_test("read backpressure", errs);

        errs = err_cnt;
        run_write(1'b0, 12'h5a0, 4, 1'b0, 1'b0);  // bit 10 set, doubled latency
        run_write(1'b1, 12'h5a0, 4, 1'b0, 1'b0);
        run_read(1'b0, 12'h5a0, 4);
        run_read(1'b1, 12'h5a0, 4);
        end_test("doubled latency", errs);

        errs = err_cnt;
        run_write(1'b0, 12'h080, 16, 1'b0, 1'b1);
        run_read(1'b0, 12'h080, 16);
        end_test("write gaps", errs);

        $display("%0d tests, %0d checks, %0d errors", test_no, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: bench/hyperram_model.sv
// word-level HyperRAM model
//   two devices, one word array per chip select
//   command-address decode, latency request on address bit 10
//   strobed writes, read words one cycle after each bus clock
module hyperram_model import hyperbus_pkg::*; #(
    parameter int unsigned WAIT_CYCLES = 6
) (
    input  logic         clk0,
    input  logic         rst_ni,
    input  hyper_bus_o_t ctrl_i,
    output hyper_bus_i_t resp_o
);
    timeunit 1ns;
    timeprecision 100ps;

    hyper_word_t mem [NR_CS][4096];
    logic [1:0]  ca_cnt_q;   // CA words seen so far
    logic [31:0] ca_q;       // first two CA words
    logic        read_q;
    logic        lat2_q;
    logic        cs_q;
    logic [11:0] addr_q;
    int unsigned lat_q;      // latency clocks still to wait

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            ca_cnt_q <= '0;
            lat_q    <= 0;
            resp_o   <= '0;
        end else begin
            resp_o.rwds <= 1'b0;
            if (&ctrl_i.cs_n) begin
                ca_cnt_q <= '0;  // deselected, next access opens with CA
            end else if (ctrl_i.ck_en) begin
                if (ca_cnt_q != 2'd3) begin
                    ca_cnt_q <= ca_cnt_q + 2'd1;
                    ca_q     <= {ca_q[15:0], ctrl_i.dq};
                    if (ca_cnt_q == 2'd0) begin
                        cs_q <= ctrl_i.cs_n[0];  // cs0 high means device 1
                    end
                    if (ca_cnt_q == 2'd1) begin
                        lat2_q      <= ctrl_i.dq[7];  // address bit 10
                        resp_o.rwds <= ctrl_i.dq[7];  // ask for doubled latency
                    end
                    if (ca_cnt_q == 2'd2) begin
                        read_q <= ca_q[31];
                        addr_q <= {ca_q[8:0], ctrl_i.dq[2:0]};
                        lat_q  <= lat2_q ? 2 * WAIT_CYCLES : WAIT_CYCLES;
                    end
                end else if (lat_q != 0) begin
                    lat_q <= lat_q - 1;
                end else begin
                    if (read_q) begin
                        resp_o.dq   <= mem[cs_q][addr_q];
                        resp_o.rwds <= 1'b1;  // data valid
                    end else begin
                        if (!ctrl_i.rwds[0]) begin
                            mem[cs_q][addr_q][7:0] <= ctrl_i.dq[7:0];
                        end
                        if (!ctrl_i.rwds[1]) begin
                            mem[cs_q][addr_q][15:8] <= ctrl_i.dq[15:8];
                        end
                    end
                    addr_q <= addr_q + 12'd1;  // linear burst
                end
            end
        end
    end

endmodule

// File: hdl/hyperbus_phy.sv
// HyperBus PHY top level
//   request, write and read valid/ready channels
//   command-address block, shared phase counter, transaction FSM
//   tx FIFO for write words, rx FIFO for read words
//   word-level bus, one 16-bit word per clk0 cycle
module hyperbus_phy import hyperbus_pkg::*; #(
    parameter int unsigned WAIT_CYCLES = 6,
    parameter int unsigned FIFO_DEPTH  = 8
) (
    input  logic         clk0,
    input  logic         rst_ni,
    // request channel
    input  logic         trans_valid_i,
    output logic         trans_ready_o,
    input  trans_req_t   trans_i,
    // write channel
    input  logic         tx_valid_i,
    output logic         tx_ready_o,
    input  tx_word_t     tx_i,
    // read channel
    output logic         rx_valid_o,
    input  logic         rx_ready_i,
    output hyper_word_t  rx_o,
    // bus
    output hyper_bus_o_t bus_o,
    input  hyper_bus_i_t bus_i
);

    trans_req_t             req_q;
    hyper_word_t            ca_word;
    logic                   ca_next;
    logic                   cnt_load, cnt_step, cnt_zero;
    logic [BURST_WIDTH-1:0] cnt_value;
    logic                   tx_full, tx_empty, tx_pop;
    tx_word_t               tx_head;
    logic                   rx_push, rx_empty, rx_almost_full;

    hyper_cmd_addr u_cmd_addr (
        .clk0      ( clk0                          ),
        .rst_ni    ( rst_ni                        ),
        .capture_i ( trans_valid_i & trans_ready_o ),
        .req_i     ( trans_i                       ),
        .ca_next_i ( ca_next                       ),
        .req_o     ( req_q                         ),
        .ca_word_o ( ca_word                       )
    );

    hyper_latency_counter #(.WIDTH(BURST_WIDTH)) u_counter (
        .clk0         ( clk0      ),
        .rst_ni       ( rst_ni    ),
        .load_i       ( cnt_load  ),
        .load_value_i ( cnt_value ),
        .step_i       ( cnt_step  ),
        .zero_o       ( cnt_zero  )
    );

    hyper_trans_fsm #(.WAIT_CYCLES(WAIT_CYCLES)) u_fsm (
        .clk0             ( clk0           ),
        .rst_ni           ( rst_ni         ),
        .trans_valid_i    ( trans_valid_i  ),
        .trans_ready_o    ( trans_ready_o  ),
        .req_i            ( req_q          ),
        .ca_word_i        ( ca_word        ),
        .ca_next_o        ( ca_next        ),
        .cnt_load_o       ( cnt_load       ),
        .cnt_value_o      ( cnt_value      ),
        .cnt_step_o       ( cnt_step       ),
        .cnt_zero_i       ( cnt_zero       ),
        .tx_empty_i       ( tx_empty       ),
        .tx_word_i        ( tx_head        ),
        .tx_pop_o         ( tx_pop         ),
        .rx_almost_full_i ( rx_almost_full ),
        .rx_push_o        ( rx_push        ),
        .bus_i            ( bus_i          ),
        .bus_o            ( bus_o          )
    );

    hyper_word_fifo #(.T(tx_word_t), .FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .clk0          ( clk0                    ),
        .rst_ni        ( rst_ni                  ),
        .push_i        ( tx_valid_i & tx_ready_o ),
        .data_i        ( tx_i                    ),
        .full_o        ( tx_full                 ),
        .almost_full_o (                         ),
        .pop_i         ( tx_pop                  ),
        .data_o        ( tx_head                 ),
        .empty_o       ( tx_empty                )
    );

    hyper_word_fifo #(.T(hyper_word_t), .FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .clk0          ( clk0                    ),
        .rst_ni        ( rst_ni                  ),
        .push_i        ( rx_push                 ),
        .data_i        ( bus_i.dq                ),
        .full_o        (                         ),
        .almost_full_o ( rx_almost_full          ),
        .pop_i         ( rx_valid_o & rx_ready_i ),
        .data_o        ( rx_o                    ),
        .empty_o       ( rx_empty                )
    );

    assign tx_ready_o = ~tx_full;
    assign rx_valid_o = ~rx_empty;

endmodule

// File: hdl/hyper_trans_fsm.sv
// transaction state machine
//   standby, command-address, latency, data and recovery phases
//   doubled latency when the device raises rwds during CA
//   bus clock pauses on empty tx FIFO or almost full rx FIFO
//   bus outputs decoded from state
module hyper_trans_fsm import hyperbus_pkg::*; #(
    parameter int unsigned WAIT_CYCLES = 6
) (
    input  logic                   clk0,
    input  logic                   rst_ni,
    input  logic                   trans_valid_i,
    output logic                   trans_ready_o,
    input  trans_req_t             req_i,         // latched request
    input  hyper_word_t            ca_word_i,
    output logic                   ca_next_o,
    output logic                   cnt_load_o,
    output logic [BURST_WIDTH-1:0] cnt_value_o,
    output logic                   cnt_step_o,
    input  logic                   cnt_zero_i,
    input  logic                   tx_empty_i,
    input  tx_word_t               tx_word_i,
    output logic                   tx_pop_o,
    input  logic                   rx_almost_full_i,
    output logic                   rx_push_o,
    input  hyper_bus_i_t           bus_i,
    output hyper_bus_o_t           bus_o
);

    typedef enum logic [2:0] {
        STANDBY, CMD_ADDR, LATENCY2, LATENCY, DATA_W, DATA_R, RECOVER
    } state_e;

    localparam logic [BURST_WIDTH-1:0] WAIT_LOAD = BURST_WIDTH'(WAIT_CYCLES - 1);
    localparam logic [BURST_WIDTH-1:0] CA_LOAD   = BURST_WIDTH'(CA_WORDS - 1);

    state_e state_q, state_d;
    logic   extra_lat_q;  // device asked for doubled latency
    logic   rd_done_q;    // last read word requested, one still in flight
    logic   data_clk;     // bus clock in a data phase

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= STANDBY;
            extra_lat_q <= 1'b0;
            rd_done_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == STANDBY) begin
                extra_lat_q <= 1'b0;
            end else if (state_q == CMD_ADDR && bus_i.rwds) begin
                extra_lat_q <= 1'b1;
            end
            if (state_q != DATA_R) begin
                rd_done_q <= 1'b0;
            end else if (data_clk && cnt_zero_i) begin
                rd_done_q <= 1'b1;
            end
        end
    end

    always_comb begin
        state_d     = state_q;
        cnt_load_o  = 1'b0;
        cnt_value_o = WAIT_LOAD;
        cnt_step_o  = 1'b0;
        ca_next_o   = 1'b0;
        tx_pop_o    = 1'b0;
        data_clk    = 1'b0;
        case (state_q)
            STANDBY: begin
                if (trans_valid_i) begin
                    state_d     = CMD_ADDR;
                    cnt_load_o  = 1'b1;
                    cnt_value_o = CA_LOAD;
                end
            end
            CMD_ADDR: begin
                if (cnt_zero_i) begin
                    cnt_load_o = 1'b1;
                    // rwds may rise on the last CA word as well
                    state_d    = (extra_lat_q || bus_i.rwds) ? LATENCY2 : LATENCY;
                end else begin
                    cnt_step_o = 1'b1;
                    ca_next_o  = 1'b1;
                end
            end
            LATENCY2: begin
                if (cnt_zero_i) begin
                    cnt_load_o = 1'b1;
                    state_d    = LATENCY;
                end else begin
                    cnt_step_o = 1'b1;
                end
            end
            LATENCY: begin
                if (cnt_zero_i) begin
                    cnt_load_o  = 1'b1;
                    cnt_value_o = req_i.burst - 1'b1;
                    state_d     = req_i.write ? DATA_W : DATA_R;
                end else begin
                    cnt_step_o = 1'b1;
                end
            end
            DATA_W: begin
                if (!tx_empty_i) begin
                    data_clk = 1'b1;
                    tx_pop_o = 1'b1;
                    if (cnt_zero_i) begin
                        cnt_load_o = 1'b1;
                        state_d    = RECOVER;
                    end else begin
                        cnt_step_o = 1'b1;
                    end
                end
            end
            DATA_R: begin
                if (!rd_done_q && !rx_almost_full_i) begin
                    data_clk   = 1'b1;
                    cnt_step_o = !cnt_zero_i;
                end
                if (rd_done_q && bus_i.rwds) begin  // last word arrives
                    cnt_load_o = 1'b1;
                    state_d    = RECOVER;
                end
            end
            RECOVER: begin
                if (cnt_zero_i) begin
                    state_d = STANDBY;
                end else begin
                    cnt_step_o = 1'b1;
                end
            end
            default: state_d = STANDBY;
        endcase
    end

    assign trans_ready_o = (state_q == STANDBY);
    assign rx_push_o     = (state_q == DATA_R) && bus_i.rwds;

    always_comb begin
        bus_o      = '0;
        bus_o.cs_n = '1;
        case (state_q)
            CMD_ADDR: begin
                bus_o.cs_n  = ~req_i.cs;
                bus_o.ck_en = 1'b1;
                bus_o.dq    = ca_word_i;
                bus_o.dq_oe = 1'b1;
            end
            LATENCY2, LATENCY: begin
                bus_o.cs_n  = ~req_i.cs;
                bus_o.ck_en = 1'b1;
            end
            DATA_W: begin
                bus_o.cs_n    = ~req_i.cs;
                bus_o.ck_en   = data_clk;
                bus_o.dq      = tx_word_i.data;
                bus_o.dq_oe   = 1'b1;
                bus_o.rwds    = ~tx_word_i.strb;  // high masks the byte
                bus_o.rwds_oe = 1'b1;
            end
            DATA_R: begin
                bus_o.cs_n  = ~req_i.cs;
                bus_o.ck_en = data_clk;
            end
            default: ;
        endcase
    end

    // request captured in the command-address block selects exactly one device
    a_cs_onehot : assert property (
        @(posedge clk0) disable iff (!rst_ni)
        state_q == CMD_ADDR |-> $onehot(req_i.cs)
    ) else $error("latched chip select not one-hot");

endmodule

// File: hdl/hyper_word_fifo.sv
// synchronous word FIFO
//   payload type given by parameter
//   circular buffer with read and write pointers and a fill count
//   almost full two entries before full
module hyper_word_fifo #(
    parameter type         T          = logic [15:0],
    parameter int unsigned FIFO_DEPTH = 8
) (
    input  logic clk0,
    input  logic rst_ni,
    input  logic push_i,
    input  T     data_i,
    output logic full_o,
    output logic almost_full_o,
    input  logic pop_i,
    output T     data_o,
    output logic empty_o
);

    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);
    localparam logic [CNT_W-1:0] AF_CNT   = CNT_W'(FIFO_DEPTH - 2);

    T                 mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk0) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;  // both or neither
            endcase
        end
    end

    assign data_o        = mem_q[rd_ptr_q];  // head word, valid when not empty
    assign empty_o       = (count_q == '0);
    assign full_o        = (count_q == FULL_CNT);
    assign almost_full_o = (count_q >= AF_CNT);

    a_no_overflow : assert property (
        @(posedge clk0) disable iff (!rst_ni)
        push_i |-> !full_o
    ) else $error("push into full FIFO");

    a_no_underflow : assert property (
        @(posedge clk0) disable iff (!rst_ni)
        pop_i |-> !empty_o
    ) else $error("pop from empty FIFO");

endmodule

// File: hdl/hyper_latency_counter.sv
// loadable down counter
//   shared by latency, burst and recovery phases
//   reports when the count has reached zero
module hyper_latency_counter import hyperbus_pkg::*; #(
    parameter int unsigned WIDTH = BURST_WIDTH
) (
    input  logic             clk0,
    input  logic             rst_ni,
    input  logic             load_i,
    input  logic [WIDTH-1:0] load_value_i,
    input  logic             step_i,        // decrement by one
    output logic             zero_o
);

    logic [WIDTH-1:0] count_q;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= load_value_i;  // load wins over step
        end else if (step_i) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign zero_o = (count_q == '0);

    // the FSM must leave its phase at zero instead of stepping past it
    a_no_step_at_zero : assert property (
        @(posedge clk0) disable iff (!rst_ni)
        step_i |-> !zero_o
    ) else $error("counter stepped below zero");

endmodule

// File: hdl/hyper_cmd_addr.sv
// command-address generation
//   holds the accepted request for the whole transaction
//   builds the 48-bit command-address word from it
//   steps through the three bus words on request
module hyper_cmd_addr import hyperbus_pkg::*; (
    input  logic        clk0,
    input  logic        rst_ni,
    input  logic        capture_i,  // request accepted this cycle
    input  trans_req_t  req_i,
    input  logic        ca_next_i,  // advance to the next CA word
    output trans_req_t  req_o,
    output hyper_word_t ca_word_o
);

    trans_req_t          req_q;
    logic [1:0]          word_idx_q;
    logic [CA_WIDTH-1:0] ca;

    // payload only, qualified by the FSM state
    always_ff @(posedge clk0) begin
        if (capture_i) begin
            req_q <= req_i;
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            word_idx_q <= '0;
        end else if (capture_i) begin
            word_idx_q <= '0;
        end else if (ca_next_i) begin
            word_idx_q <= word_idx_q + 2'd1;
        end
    end

    // read flag, memory space, linear burst, then split address
    assign ca = {~req_q.write, 1'b0, 1'b1, req_q.address[31:3],
                 13'b0, req_q.address[2:0]};

    always_comb begin
        case (word_idx_q)
            2'd0:    ca_word_o = ca[47:32];  // msb word first
            2'd1:    ca_word_o = ca[31:16];
            2'd2:    ca_word_o = ca[15:0];
            default: ca_word_o = '0;
        endcase
    end

    assign req_o = req_q;

endmodule

// File: hdl/hyperbus_pkg.sv
// shared types for the HyperBus PHY
//   bus width and chip select constants
//   write and read payload types
//   transaction request struct
//   word-level bus output and input structs
package hyperbus_pkg;

    localparam int unsigned NR_CS       = 2;   // chip selects on the bus
    localparam int unsigned BURST_WIDTH = 12;  // burst length field
    localparam int unsigned DQ_WIDTH    = 16;  // one DDR clock carries a full word
    localparam int unsigned STRB_WIDTH  = DQ_WIDTH / 8;
    localparam int unsigned CA_WORDS    = 3;   // command-address words per transaction
    localparam int unsigned CA_WIDTH    = CA_WORDS * DQ_WIDTH;

    // one word as seen on dq
    typedef logic [DQ_WIDTH-1:0] hyper_word_t;

    // write payload, strb high means the byte is written
    typedef struct packed {
        hyper_word_t           data;
        logic [STRB_WIDTH-1:0] strb;
    } tx_word_t;

    // transaction request from the host side
    typedef struct packed {
        logic [31:0]            address;  // word address
        logic [NR_CS-1:0]       cs;       // one-hot
        logic                   write;
        logic [BURST_WIDTH-1:0] burst;    // words, at least 1
    } trans_req_t;

    // controller to device
    typedef struct packed {
        logic [NR_CS-1:0]      cs_n;     // active low
        logic                  ck_en;    // bus clock runs this cycle
        hyper_word_t           dq;
        logic                  dq_oe;
        logic [STRB_WIDTH-1:0] rwds;     // byte mask during writes
        logic                  rwds_oe;
    } hyper_bus_o_t;

    // device to controller
    // rwds doubles as latency request in CA and data valid in reads
    typedef struct packed {
        hyper_word_t dq;
        logic        rwds;
    } hyper_bus_i_t;

endpackage
